// File: include/antilog_lut.svh
////////////////////
// Include inside a module that imports antilog_pkg
////////////////////
`ifndef ANTILOG_LUT_SVH
`define ANTILOG_LUT_SVH

// One octave of 2^x, entry = (2^(idx/64) - 1) * 2^23
function automatic frac_t antilog_frac(input logic [5:0] idx);
  case (idx)
    6'd0: antilog_frac = 23'd0;
    6'd1: antilog_frac = 23'd91346;
    6'd2: antilog_frac = 23'd183687;
    6'd3: antilog_frac = 23'd277033;
    6'd4: antilog_frac = 23'd371395;
    6'd5: antilog_frac = 23'd466786;
    6'd6: antilog_frac = 23'd563215;
    6'd7: antilog_frac = 23'd660693;
    6'd8: antilog_frac = 23'd759234;
    6'd9: antilog_frac = 23'd858847;
    6'd10: antilog_frac = 23'd959546;
    6'd11: antilog_frac = 23'd1061340;
    6'd12: antilog_frac = 23'd1164243;
    6'd13: antilog_frac = 23'd1268267;
    6'd14: antilog_frac = 23'd1373424;
    6'd15: antilog_frac = 23'd1479725;
    6'd16: antilog_frac = 23'd1587184;
    6'd17: antilog_frac = 23'd1695814;
    6'd18: antilog_frac = 23'd1805626;
    6'd19: antilog_frac = 23'd1916634;
    6'd20: antilog_frac = 23'd2028850;
    6'd21: antilog_frac = 23'd2142289;
    6'd22: antilog_frac = 23'd2256963;
    6'd23: antilog_frac = 23'd2372886;
    6'd24: antilog_frac = 23'd2490071;
    6'd25: antilog_frac = 23'd2608532;
    6'd26: antilog_frac = 23'd2728283;
    6'd27: antilog_frac = 23'd2849338;
    6'd28: antilog_frac = 23'd2971711;
    6'd29: antilog_frac = 23'd3095417;
    6'd30: antilog_frac = 23'd3220470;
    6'd31: antilog_frac = 23'd3346884;
    6'd32: antilog_frac = 23'd3474675;
    6'd33: antilog_frac = 23'd3603858;
    6'd34: antilog_frac = 23'd3734447;
    6'd35: antilog_frac = 23'd3866459;
    6'd36: antilog_frac = 23'd3999908;
    6'd37: antilog_frac = 23'd4134810;
    6'd38: antilog_frac = 23'd4271181;
    6'd39: antilog_frac = 23'd4409037;
    6'd40: antilog_frac = 23'd4548394;
    6'd41: antilog_frac = 23'd4689269;
    6'd42: antilog_frac = 23'd4831678;
    6'd43: antilog_frac = 23'd4975637;
    6'd44: antilog_frac = 23'd5121164;
    6'd45: antilog_frac = 23'd5268276;
    6'd46: antilog_frac = 23'd5416990;
    6'd47: antilog_frac = 23'd5567323;
    6'd48: antilog_frac = 23'd5719293;
    6'd49: antilog_frac = 23'd5872918;
    6'd50: antilog_frac = 23'd6028216;
    6'd51: antilog_frac = 23'd6185205;
    6'd52: antilog_frac = 23'd6343903;
    6'd53: antilog_frac = 23'd6504329;
    6'd54: antilog_frac = 23'd6666503;
    6'd55: antilog_frac = 23'd6830442;
    6'd56: antilog_frac = 23'd6996167;
    6'd57: antilog_frac = 23'd7163696;
    6'd58: antilog_frac = 23'd7333050;
    6'd59: antilog_frac = 23'd7504247;
    6'd60: antilog_frac = 23'd7677309;
    6'd61: antilog_frac = 23'd7852255;
    6'd62: antilog_frac = 23'd8029107;
    default: antilog_frac = 23'd8207884;
  endcase
endfunction

`endif

// File: rtl/antilog_pkg.sv
////////////////////
// Number formats of the antilog datapath and the lane issue/result records
// Results wrap silently above 26 integer bits
////////////////////
package antilog_pkg;

  ////////////////////
  // Number formats
  ////////////////////

  // 6.6 exponent, [11:6] integer shift, [5:0] fraction index
  typedef logic [11:0] exp_t;

  // Table entry, (2^(f/64) - 1) * 2^23 rounded
  typedef logic [22:0] frac_t;

  // 26.8 result
  typedef logic [33:0] pow_t;

  // Mantissa has 23 fraction bits, the result keeps 8
  localparam int unsigned POW_SHIFT = 15;

  // Cycles from issue valid to result valid
  localparam int unsigned LANE_LATENCY = 2;

  ////////////////////
  // Lane records
  ////////////////////

  typedef struct packed {
    logic valid;
    exp_t exponent;
  } lane_issue_t;

  typedef struct packed {
    logic valid;
    pow_t value;
  } lane_result_t;

endpackage

// File: rtl/wb_pkg.sv
////////////////////
// Wishbone classic slave types and register map
// Word addressed, no byte selects
////////////////////
package wb_pkg;

  // [5:4] region, [3:0] lane index
  typedef logic [5:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // Region codes of the register map
  typedef logic [1:0] wb_region_t;

  // Write only, low 12 bits hold the exponent
  localparam wb_region_t REG_EXP = 2'd0;
  // Result bits 31:0
  localparam wb_region_t REG_RES_LO = 2'd1;
  // Result bits 33:32, zero extended
  localparam wb_region_t REG_RES_HI = 2'd2;
  // One done flag per lane
  localparam wb_region_t REG_STATUS = 2'd3;

  // Request as seen on the bus in one cycle
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

endpackage

// File: rtl/antilog_lane.sv
////////////////////
// 2^x of one 6.6 exponent, LANE_LATENCY cycles, one new item per cycle
// Integer parts above 25 wrap, no saturation
////////////////////
`timescale 1ns/1ns

module antilog_lane import antilog_pkg::*; (
  input logic clk,
  input logic rst,
  input lane_issue_t issue,
  output lane_result_t res
);

  `include "antilog_lut.svh"

  // Only bits up to POW_SHIFT + 33 reach the result
  localparam int unsigned MANT_W = $bits(pow_t) + POW_SHIFT;

  // Stage 1, table entry and shift count
  logic s1_valid;
  frac_t s1_frac;
  logic [5:0] s1_shift;

  // Stage 2, shifted mantissa slice
  logic [MANT_W-1:0] mant;
  logic res_valid;
  pow_t res_value;

  ////////////////////
  // Valid pipe
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid <= issue.valid;
      res_valid <= s1_valid;
    end
  end

  ////////////////////
  // Datapath
  ////////////////////
  // Clocked every cycle so back to back items advance
  always_ff @(posedge clk) begin
    s1_frac <= antilog_frac(issue.exponent[5:0]);
    s1_shift <= issue.exponent[11:6];
    res_value <= mant[MANT_W-1:POW_SHIFT];
  end

  // Implicit one above the entry, high bits drop out
  assign mant = MANT_W'({1'b1, s1_frac}) << s1_shift;

  assign res = '{valid: res_valid, value: res_value};

endmodule

// File: rtl/antilog_wb_front.sv
////////////////////
// Wishbone classic slave, single cycles only, ack one cycle after the request
// Writes to read-only regions or lanes >= NUM_LANES are acked and dropped
////////////////////
`timescale 1ns/1ns

module antilog_wb_front import antilog_pkg::*, wb_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input logic clk,
  input logic rst,
  input logic cyc,
  input logic stb,
  input logic we,
  input wb_adr_t adr,
  input wb_dat_t dat_w,
  output wb_dat_t dat_r,
  output logic ack,
  output lane_issue_t issue [NUM_LANES],
  output logic [NUM_LANES-1:0] clear,
  output logic [3:0] rd_index,
  output wb_region_t rd_region,
  input wb_dat_t rd_data
);

  wb_req_t req;
  // New request, not the one already being acked
  logic req_hit;
  logic exp_wr;
  logic [NUM_LANES-1:0] issue_valid;
  exp_t issue_exp;

  ////////////////////
  // Decode
  ////////////////////
  assign req = '{cyc: cyc, stb: stb, we: we, adr: adr, dat: dat_w};
  assign req_hit = req.cyc && req.stb && !ack;

  // Bank sees the address directly, answer is registered below
  assign rd_region = wb_region_t'(req.adr[5:4]);
  assign rd_index = req.adr[3:0];

  assign exp_wr = req_hit && req.we && (rd_region == REG_EXP);

  ////////////////////
  // Control
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
      issue_valid <= '0;
    end else begin
      ack <= req_hit;
      // One hot pulse, no lane matches an index out of range
      for (int k = 0; k < NUM_LANES; k++) begin
        issue_valid[k] <= exp_wr && (rd_index == 4'(k));
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (exp_wr) begin
      issue_exp <= exp_t'(req.dat);
    end
    // Read data lands with ack, writes return zero
    if (req_hit) begin
      dat_r <= req.we ? '0 : rd_data;
    end
  end

  // Done flag drops with the issue
  assign clear = issue_valid;

  // Every lane sees the same exponent, only its valid differs
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      issue[k] = '{valid: issue_valid[k], exponent: issue_exp};
    end
  end

endmodule

// File: rtl/antilog_result_bank.sv
////////////////////
// Last result and done flag per lane, read is combinational
// Reads never clear flags, indices >= NUM_LANES read as zero
////////////////////
`timescale 1ns/1ns

module antilog_result_bank import antilog_pkg::*, wb_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input logic clk,
  input logic rst,
  input lane_result_t res [NUM_LANES],
  input logic [NUM_LANES-1:0] clear,
  input logic [3:0] rd_index,
  input wb_region_t rd_region,
  output wb_dat_t rd_data
);

  pow_t value_q [NUM_LANES];
  logic [NUM_LANES-1:0] done;
  // Result of the addressed lane
  pow_t sel;

  // Latest result overwrites
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (res[k].valid) begin
        value_q[k] <= res[k].value;
      end
    end
  end

  // Result beats a clear on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= '0;
    end else begin
      for (int k = 0; k < NUM_LANES; k++) begin
        if (res[k].valid) begin
          done[k] <= 1'b1;
        end else if (clear[k]) begin
          done[k] <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Read mux
  ////////////////////
  always_comb begin
    sel = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (rd_index == 4'(k)) begin
        sel = value_q[k];
      end
    end
    case (rd_region)
      REG_RES_LO: rd_data = sel[31:0];
      REG_RES_HI: rd_data = wb_dat_t'(sel[33:32]);
      REG_STATUS: rd_data = wb_dat_t'(done);
      // Exponent region is write only
      default: rd_data = '0;
    endcase
  end

endmodule

// File: rtl/antilog_top.sv
////////////////////
// Antilog accelerator, NUM_LANES from 1 to 16 behind one Wishbone classic port
////////////////////
`timescale 1ns/1ns

module antilog_top import antilog_pkg::*, wb_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input logic clk,
  input logic rst,
  // Wishbone classic slave
  input logic cyc,
  input logic stb,
  input logic we,
  input wb_adr_t adr,
  input wb_dat_t dat_w,
  output wb_dat_t dat_r,
  output logic ack
);

  // Front end to lanes and bank
  lane_issue_t issue [NUM_LANES];
  logic [NUM_LANES-1:0] clear;
  logic [3:0] rd_index;
  wb_region_t rd_region;
  wb_dat_t rd_data;
  // Lanes to bank
  lane_result_t res [NUM_LANES];

  antilog_wb_front #(
    .NUM_LANES(NUM_LANES)
  ) antilog_wb_front_inst (
    .clk(clk),
    .rst(rst),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .dat_w(dat_w),
    .dat_r(dat_r),
    .ack(ack),
    .issue(issue),
    .clear(clear),
    .rd_index(rd_index),
    .rd_region(rd_region),
    .rd_data(rd_data)
  );

  ////////////////////
  // Lanes
  ////////////////////
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    antilog_lane antilog_lane_inst (
      .clk(clk),
      .rst(rst),
      .issue(issue[k]),
      .res(res[k])
    );
  end

  antilog_result_bank #(
    .NUM_LANES(NUM_LANES)
  ) antilog_result_bank_inst (
    .clk(clk),
    .rst(rst),
    .res(res),
    .clear(clear),
    .rd_index(rd_index),
    .rd_region(rd_region),
    .rd_data(rd_data)
  );

endmodule

// File: tb/antilog_assert.sv
////////////////////
// Bus and lane timing properties, bound into antilog_top
////////////////////
`timescale 1ns/1ns

module antilog_assert import antilog_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input logic clk,
  input logic rst,
  input logic cyc,
  input logic stb,
  input logic ack,
  input lane_issue_t issue [NUM_LANES],
  input lane_result_t res [NUM_LANES]
);

  logic [NUM_LANES-1:0] issue_v;
  logic [NUM_LANES-1:0] res_v;
  // Failures per property
  int unsigned len_fails = 0;
  int unsigned req_fails = 0;
  int unsigned lat_fails = 0;
  int unsigned rst_fails = 0;
  int unsigned fail_count;

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      issue_v[k] = issue[k].valid;
      res_v[k] = res[k].valid;
    end
  end

  assign fail_count = len_fails + req_fails + lat_fails + rst_fails;

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else begin
      len_fails++;
      $error("ack held for more than one cycle");
    end

  // Ack only for a strobe seen on the previous edge
  ack_after_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(cyc && stb))
    else begin
      req_fails++;
      $error("ack without a preceding request");
    end

  lane_latency: assert property (@(posedge clk) disable iff (rst)
    res_v == $past(issue_v, LANE_LATENCY))
    else begin
      lat_fails++;
      $error("lane result valid off its issue by LANE_LATENCY");
    end

  ack_in_reset: assert property (@(posedge clk) rst |=> !ack)
    else begin
      rst_fails++;
      $error("ack high during reset");
    end

endmodule

bind antilog_top antilog_assert #(
  .NUM_LANES(NUM_LANES)
) antilog_assert_inst (
  .clk(clk),
  .rst(rst),
  .cyc(cyc),
  .stb(stb),
  .ack(ack),
  .issue(issue),
  .res(res)
);

// File: tb/antilog_tb.sv
////////////////////
// Four lane testbench, every read is compared against the 26.8 reference rule
// Any wait that runs out ends the run at once
////////////////////
`timescale 1ns/1ns

module antilog_tb import antilog_pkg::*, wb_pkg::*; ();

  localparam int NUM_LANES = 4;
  localparam int ACK_TIMEOUT = 20;
  localparam int DONE_TIMEOUT = 20;

  // Lane include in the same compilation unit already set the guard
  `undef ANTILOG_LUT_SVH
  `include "antilog_lut.svh"

  logic clk;
  logic rst;
  logic cyc;
  logic stb;
  logic we;
  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_dat_t dat_r;
  logic ack;

  int seed;
  int checks;
  int errors;
  // Reads waiting for the compare process
  logic [33:0] got_q[$];
  logic [33:0] exp_q[$];
  string what_q[$];
  // Expected result of the last exponent written per lane
  pow_t lane_ref [NUM_LANES];

  antilog_top #(
    .NUM_LANES(NUM_LANES)
  ) antilog_top_inst (
    .clk(clk),
    .rst(rst),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .dat_w(dat_w),
    .dat_r(dat_r),
    .ack(ack)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////
  // Reference and compare
  ////////////////////
  // (2^23 + entry) << int, result is bits 48:15, upper bits wrap away
  function automatic pow_t ref_pow(input exp_t e);
    logic [87:0] mant;
    mant = {64'd0, 1'b1, antilog_frac(e[5:0])} << e[11:6];
    return mant[48:15];
  endfunction

  task automatic check_value(input logic [33:0] got, input logic [33:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic expect_value(input logic [33:0] got, input logic [33:0] expected,
                              input string what);
    got_q.push_back(got);
    exp_q.push_back(expected);
    what_q.push_back(what);
  endtask

  // Compare process, drains whatever the stimulus queued
  always @(posedge clk) begin
    while (got_q.size() > 0) begin
      check_value(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
    end
  end

  task automatic report_counts();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             antilog_top_inst.antilog_assert_inst.fail_count);
  endtask

  task automatic abort_run(input string what);
    $display("Timed out waiting for %s", what);
    report_counts();
    $display("Simulation failed");
    $finish;
  endtask

  ////////////////////
  // Wishbone driver
  ////////////////////
  task automatic wait_ack(input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!ack && n < ACK_TIMEOUT);
    if (!ack) abort_run(what);
  endtask

  task automatic wb_write(input wb_region_t region, input logic [3:0] index,
                          input wb_dat_t data);
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b1;
    adr = {region, index};
    dat_w = data;
    wait_ack("write ack");
    // Drop the strobe in the ack cycle
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic wb_read(input wb_region_t region, input logic [3:0] index,
                         output wb_dat_t data);
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = {region, index};
    wait_ack("read ack");
    data = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  // Poll status until every lane in mask reports done
  task automatic wait_done(input logic [NUM_LANES-1:0] mask);
    wb_dat_t status;
    int n;
    n = 0;
    status = '0;
    while ((status[NUM_LANES-1:0] & mask) != mask && n < DONE_TIMEOUT) begin
      wb_read(REG_STATUS, 4'd0, status);
      n++;
    end
    if ((status[NUM_LANES-1:0] & mask) != mask) abort_run("lane done flags");
  endtask

  task automatic write_exp(input int lane, input exp_t e);
    wb_write(REG_EXP, 4'(lane), wb_dat_t'(e));
    lane_ref[lane] = ref_pow(e);
  endtask

  // Low and high words of one lane result
  task automatic check_lane(input int lane, input pow_t expected);
    wb_dat_t lo;
    wb_dat_t hi;
    wb_read(REG_RES_LO, 4'(lane), lo);
    wb_read(REG_RES_HI, 4'(lane), hi);
    expect_value({2'b00, lo}, {2'b00, expected[31:0]}, $sformatf("lane %0d low word", lane));
    expect_value({2'b00, hi}, {32'd0, expected[33:32]}, $sformatf("lane %0d high word", lane));
  endtask

  task automatic run_single(input int lane, input exp_t e);
    write_exp(lane, e);
    wait_done(4'(1 << lane));
    check_lane(lane, lane_ref[lane]);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    wb_dat_t status;
    int n;
    clk = 1'b0;
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    seed = 32'hb9d769d3;
    checks = 0;
    errors = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Idle bus, no ack and no done flags
    repeat (5) begin
      @(posedge clk);
      #1;
      expect_value(34'(ack), 34'd0, "ack without request");
    end
    wb_read(REG_STATUS, 4'd0, status);
    expect_value({2'b00, status}, 34'd0, "status after reset");

    // Directed exponents on lane 0, 1.0 is 256 in 26.8
    write_exp(0, 12'd0);
    wait_done(4'b0001);
    check_lane(0, 34'd256);
    for (int f = 0; f < 64; f++) begin
      run_single(0, exp_t'(f));
    end
    run_single(0, {6'd1, 6'd0});
    run_single(0, {6'd10, 6'd17});
    run_single(0, {6'd25, 6'd63});
    // Integer part 40 wraps
    run_single(0, {6'd40, 6'd5});

    // Random exponents on all lanes back to back
    repeat (8) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        write_exp(k, exp_t'($random(seed)));
      end
      wait_done('1);
      for (int k = 0; k < NUM_LANES; k++) begin
        check_lane(k, lane_ref[k]);
      end
    end

    // Two writes in flight in one lane, second one is kept
    write_exp(2, {6'd3, 6'd12});
    write_exp(2, {6'd7, 6'd50});
    wait_done(4'b0100);
    check_lane(2, ref_pow({6'd7, 6'd50}));
    wb_read(REG_STATUS, 4'd0, status);
    expect_value(34'(status[2]), 34'd1, "lane 2 done after double write");

    // Write clears the flag, result sets it again
    write_exp(1, {6'd2, 6'd33});
    wb_read(REG_STATUS, 4'd0, status);
    expect_value({2'b00, status}, 34'hd, "status after lane 1 issue");
    wait_done(4'b0010);
    check_lane(1, lane_ref[1]);

    // Lane index 7 is out of range
    wb_write(REG_EXP, 4'd7, 32'h0000_0abc);
    wb_read(REG_STATUS, 4'd0, status);
    expect_value({2'b00, status}, 34'hf, "status after lane 7 write");
    for (int k = 0; k < NUM_LANES; k++) begin
      check_lane(k, lane_ref[k]);
    end
    check_lane(7, '0);

    // Let the compare process catch up
    n = 0;
    while (got_q.size() > 0 && n < ACK_TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (got_q.size() > 0) begin
      abort_run("the compare queue to drain");
    end else begin
      report_counts();
      if (errors == 0 && antilog_top_inst.antilog_assert_inst.fail_count == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+include
rtl/antilog_pkg.sv
rtl/wb_pkg.sv
rtl/antilog_lane.sv
rtl/antilog_wb_front.sv
rtl/antilog_result_bank.sv
rtl/antilog_top.sv
tb/antilog_assert.sv
tb/antilog_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= antilog_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
